// File: verilog.f
source/mem_pkg.sv
source/ifu.sv
source/lsu.sv
source/axi_arbiter.sv
source/axi_sram.sv
source/mem_top.sv
dv/tb_mem_top.sv

// File: Makefile
# Verilator build and run of the memory front end testbench

TOP       ?= tb_mem_top
FILELIST  ?= verilog.f
VERILATOR ?= verilator
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: TOP FILELIST VERILATOR BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/tb_mem_top.sv
`timescale 1ns/1ps

module tb_mem_top
    import mem_pkg::*;
();

    localparam logic [addr_width-1:0] RESET_PC  = 32'h8000_0000;
    localparam int                    MEM_WORDS = 256;
    localparam int                    LATENCY   = 3;
    localparam int                    timeout_cycles = 200;
    localparam int                    num_rows = 15;

    typedef enum logic [2:0] {
        act_store,
        act_load,
        act_retire,
        act_jump,
        act_pair
    } act_e;

    // pair rows keep the expected inst in data and the load result in exp
    typedef struct packed {
        act_e        act;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
    } row_t;

    logic        clk;
    logic        rst;
    logic        finish;
    logic        jump_en;
    logic [31:0] jump_pc;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        inst_valid;
    logic        difftest;
    logic        itrace_reg;
    logic        lsu_req;
    lsu_op_e     lsu_op;
    logic [31:0] lsu_addr;
    logic [31:0] lsu_wdata;
    logic        lsu_busy;
    logic        lsu_done;
    logic [31:0] lsu_rdata;

    row_t        rows [num_rows];
    logic [31:0] model_mem [MEM_WORDS];
    logic [31:0] lfsr_state;
    logic [31:0] build_pc;
    logic [31:0] exp_pc;
    logic [31:0] seen_inst;
    logic [31:0] seen_pc;
    logic [31:0] seen_rdata;
    logic        timed_out;
    int          dt_count;
    int          it_count;
    int          checks;
    int          errors;

    mem_top #(
        .RESET_PC(RESET_PC),
        .MEM_WORDS(MEM_WORDS),
        .LATENCY(LATENCY)
    ) u_dut (
        .clk(clk), .rst(rst), .finish(finish), .jump_en(jump_en), .jump_pc(jump_pc),
        .pc(pc), .inst(inst), .inst_valid(inst_valid), .difftest(difftest),
        .itrace_reg(itrace_reg), .lsu_req(lsu_req), .lsu_op(lsu_op), .lsu_addr(lsu_addr),
        .lsu_wdata(lsu_wdata), .lsu_busy(lsu_busy), .lsu_done(lsu_done),
        .lsu_rdata(lsu_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    // expected values come from a word model indexed by address bits [9:2]
    task automatic add_row(input int i, input act_e act, input logic [31:0] addr);
        logic [31:0] word;
        rows[i].act  = act;
        rows[i].addr = addr;
        rows[i].data = '0;
        rows[i].exp  = '0;
        case (act)
            act_store: begin
                rand_word(word);
                rows[i].data = word;
                model_mem[addr[9:2]] = word;
            end
            act_load: rows[i].exp = model_mem[addr[9:2]];
            act_retire: begin
                build_pc = build_pc + 32'd4;
                rows[i].exp = model_mem[build_pc[9:2]];
            end
            act_jump: begin
                build_pc = addr;
                rows[i].exp = model_mem[build_pc[9:2]];
            end
            act_pair: begin
                build_pc = build_pc + 32'd4;
                rows[i].data = model_mem[build_pc[9:2]];
                rows[i].exp  = model_mem[addr[9:2]];
            end
            default: rows[i].exp = '0;
        endcase
    endtask

    task automatic build_table();
        build_pc = RESET_PC;
        add_row(0,  act_store,  32'h8000_0004);
        add_row(1,  act_store,  32'h8000_0040);
        add_row(2,  act_store,  32'h8000_0044);
        add_row(3,  act_load,   32'h8000_0004);
        // upper bits differ, same word
        add_row(4,  act_load,   32'h0000_0040);
        add_row(5,  act_store,  32'h1234_5404);
        add_row(6,  act_load,   32'h8000_0004);
        add_row(7,  act_retire, 32'h0000_0000);
        add_row(8,  act_jump,   32'h8000_0040);
        add_row(9,  act_retire, 32'h0000_0000);
        add_row(10, act_store,  32'h8000_0048);
        add_row(11, act_store,  32'h0000_0200);
        add_row(12, act_pair,   32'h0000_0200);
        add_row(13, act_store,  32'h8000_0010);
        add_row(14, act_jump,   32'h8000_0010);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors = errors + 1;
        $display("FAIL time %0t: %s expected %h, got %h", $time, name, exp, act);
    endtask

    task automatic end_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // one cycle of stimulus, then everything returns to idle
    task automatic drive(input logic fin, input logic jump, input logic [31:0] target,
                         input logic req, input lsu_op_e op, input logic [31:0] addr,
                         input logic [31:0] data);
        @(posedge clk);
        finish    <= fin;
        jump_en   <= jump;
        jump_pc   <= target;
        lsu_req   <= req;
        lsu_op    <= op;
        lsu_addr  <= addr;
        lsu_wdata <= data;
        @(posedge clk);
        finish  <= 1'b0;
        jump_en <= 1'b0;
        lsu_req <= 1'b0;
    endtask

    // sampled on the falling edge, strobes counted along the way
    task automatic wait_for(input logic want_inst, input logic want_lsu);
        int   cycles;
        logic got_inst;
        logic got_lsu;
        logic exp_busy;
        logic busy_bad;
        cycles   = 0;
        got_inst = !want_inst;
        got_lsu  = !want_lsu;
        busy_bad = 1'b0;
        dt_count = 0;
        it_count = 0;
        while (!(got_inst && got_lsu) && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles = cycles + 1;
            if (difftest) dt_count = dt_count + 1;
            if (itrace_reg) it_count = it_count + 1;
            // busy from the accepted command until the done pulse
            exp_busy = want_lsu && !got_lsu && !lsu_done;
            if (lsu_busy !== exp_busy && !busy_bad) begin
                busy_bad = 1'b1;
                report_mismatch("lsu_busy", {31'd0, exp_busy}, {31'd0, lsu_busy});
            end
            if (want_inst && !got_inst && inst_valid) begin
                got_inst  = 1'b1;
                seen_inst = inst;
                seen_pc   = pc;
            end
            if (want_lsu && !got_lsu && lsu_done) begin
                got_lsu    = 1'b1;
                seen_rdata = lsu_rdata;
            end
        end
        if (!(got_inst && got_lsu)) begin
            errors    = errors + 1;
            timed_out = 1'b1;
            if (!got_inst) $display("no inst_valid within %0d cycles", timeout_cycles);
            if (!got_lsu) $display("no lsu_done within %0d cycles", timeout_cycles);
        end
    endtask

    task automatic check_fetch(input logic [31:0] exp_inst);
        checks = checks + 1;
        if (seen_pc !== exp_pc) report_mismatch("pc", exp_pc, seen_pc);
        if (seen_inst !== exp_inst) report_mismatch("inst", exp_inst, seen_inst);
        if (dt_count != 1) begin
            errors = errors + 1;
            $display("difftest pulsed %0d times after one retire", dt_count);
        end
        if (it_count != 1) begin
            errors = errors + 1;
            $display("itrace_reg pulsed %0d times after one retire", it_count);
        end
    endtask

    task automatic apply_row(input row_t r);
        case (r.act)
            act_store: begin
                drive(1'b0, 1'b0, '0, 1'b1, op_store, r.addr, r.data);
                wait_for(1'b0, 1'b1);
            end
            act_load: begin
                drive(1'b0, 1'b0, '0, 1'b1, op_load, r.addr, '0);
                wait_for(1'b0, 1'b1);
                if (!timed_out) begin
                    checks = checks + 1;
                    if (seen_rdata !== r.exp) report_mismatch("lsu_rdata", r.exp, seen_rdata);
                end
            end
            act_retire, act_jump: begin
                exp_pc = (r.act == act_jump) ? r.addr : exp_pc + 32'd4;
                drive(1'b1, r.act == act_jump, r.addr, 1'b0, op_load, '0, '0);
                wait_for(1'b1, 1'b0);
                if (!timed_out) begin
                    check_fetch(r.exp);
                end
            end
            act_pair: begin
                exp_pc = exp_pc + 32'd4;
                drive(1'b1, 1'b0, '0, 1'b1, op_load, r.addr, '0);
                wait_for(1'b1, 1'b1);
                if (!timed_out) begin
                    check_fetch(r.data);
                    checks = checks + 1;
                    if (seen_rdata !== r.exp) report_mismatch("lsu_rdata", r.exp, seen_rdata);
                end
            end
            default: begin
                errors = errors + 1;
                $display("unknown action in the stimulus table");
            end
        endcase
    endtask

    initial begin
        rst        = 1'b1;
        finish     = 1'b0;
        jump_en    = 1'b0;
        jump_pc    = '0;
        lsu_req    = 1'b0;
        lsu_op     = op_load;
        lsu_addr   = '0;
        lsu_wdata  = '0;
        checks     = 0;
        errors     = 0;
        timed_out  = 1'b0;
        lfsr_state = 32'h4d81_63c8;
        build_table();

        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // first fetch from the reset vector, no retire yet
        exp_pc = RESET_PC;
        wait_for(1'b1, 1'b0);
        if (!timed_out) begin
            checks = checks + 1;
            if (seen_pc !== RESET_PC) report_mismatch("pc", RESET_PC, seen_pc);
            if (it_count != 1) begin
                errors = errors + 1;
                $display("itrace_reg high for %0d cycles after reset", it_count);
            end
            if (dt_count != 0) begin
                errors = errors + 1;
                $display("difftest pulsed without a retire");
            end
        end

        for (int i = 0; i < num_rows && !timed_out; i++) begin
            apply_row(rows[i]);
        end
        end_run();
    end

endmodule

// File: source/mem_top.sv
`timescale 1ns/1ps

module mem_top
    import mem_pkg::*;
#(
    parameter logic [addr_width-1:0] RESET_PC  = 32'h8000_0000,
    parameter int                    MEM_WORDS = 256,
    parameter int                    LATENCY   = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    // fetch side
    input  logic                  finish,
    input  logic                  jump_en,
    input  logic [addr_width-1:0] jump_pc,
    output logic [addr_width-1:0] pc,
    output logic [data_width-1:0] inst,
    output logic                  inst_valid,
    output logic                  difftest,
    output logic                  itrace_reg,
    // load/store command port
    input  logic                  lsu_req,
    input  lsu_op_e               lsu_op,
    input  logic [addr_width-1:0] lsu_addr,
    input  logic [data_width-1:0] lsu_wdata,
    output logic                  lsu_busy,
    output logic                  lsu_done,
    output logic [data_width-1:0] lsu_rdata
);

    logic [addr_width-1:0] ifu_araddr;
    logic                  ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
    logic [data_width-1:0] ifu_rdata;

    logic [addr_width-1:0] lsu_araddr, lsu_awaddr;
    logic [data_width-1:0] lsu_rd, lsu_wd;
    logic                  lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
    logic                  lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready;
    logic                  lsu_bvalid, lsu_bready;

    logic [addr_width-1:0] mem_araddr, mem_awaddr;
    logic [data_width-1:0] mem_rdata, mem_wdata;
    logic                  mem_arvalid, mem_arready, mem_rvalid, mem_rready;
    logic                  mem_awvalid, mem_awready, mem_wvalid, mem_wready;
    logic                  mem_bvalid, mem_bready;

    ifu #(
        .RESET_PC(RESET_PC)
    ) u_ifu (
        .clk(clk), .rst(rst), .finish(finish), .jump_en(jump_en), .jump_pc(jump_pc),
        .pc(pc), .inst(inst), .inst_valid(inst_valid), .difftest(difftest),
        .itrace_reg(itrace_reg), .araddr(ifu_araddr), .arvalid(ifu_arvalid),
        .arready(ifu_arready), .rvalid(ifu_rvalid), .rdata(ifu_rdata), .rready(ifu_rready)
    );

    lsu u_lsu (
        .clk(clk), .rst(rst), .lsu_req(lsu_req), .lsu_op(lsu_op), .lsu_addr(lsu_addr),
        .lsu_wdata(lsu_wdata), .lsu_busy(lsu_busy), .lsu_done(lsu_done),
        .lsu_rdata(lsu_rdata), .araddr(lsu_araddr), .arvalid(lsu_arvalid),
        .arready(lsu_arready), .rvalid(lsu_rvalid), .rdata(lsu_rd), .rready(lsu_rready),
        .awaddr(lsu_awaddr), .awvalid(lsu_awvalid), .awready(lsu_awready),
        .wdata(lsu_wd), .wvalid(lsu_wvalid), .wready(lsu_wready),
        .bvalid(lsu_bvalid), .bready(lsu_bready)
    );

    axi_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .ifu_araddr(ifu_araddr), .ifu_arvalid(ifu_arvalid), .ifu_arready(ifu_arready),
        .ifu_rdata(ifu_rdata), .ifu_rvalid(ifu_rvalid), .ifu_rready(ifu_rready),
        .lsu_araddr(lsu_araddr), .lsu_arvalid(lsu_arvalid), .lsu_arready(lsu_arready),
        .lsu_rdata(lsu_rd), .lsu_rvalid(lsu_rvalid), .lsu_rready(lsu_rready),
        .lsu_awaddr(lsu_awaddr), .lsu_awvalid(lsu_awvalid), .lsu_awready(lsu_awready),
        .lsu_wdata(lsu_wd), .lsu_wvalid(lsu_wvalid), .lsu_wready(lsu_wready),
        .lsu_bvalid(lsu_bvalid), .lsu_bready(lsu_bready),
        .mem_araddr(mem_araddr), .mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
        .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid), .mem_rready(mem_rready),
        .mem_awaddr(mem_awaddr), .mem_awvalid(mem_awvalid), .mem_awready(mem_awready),
        .mem_wdata(mem_wdata), .mem_wvalid(mem_wvalid), .mem_wready(mem_wready),
        .mem_bvalid(mem_bvalid), .mem_bready(mem_bready)
    );

    axi_sram #(
        .MEM_WORDS(MEM_WORDS),
        .LATENCY(LATENCY)
    ) u_sram (
        .clk(clk), .rst(rst),
        .araddr(mem_araddr), .arvalid(mem_arvalid), .arready(mem_arready),
        .rdata(mem_rdata), .rvalid(mem_rvalid), .rready(mem_rready),
        .awaddr(mem_awaddr), .awvalid(mem_awvalid), .awready(mem_awready),
        .wdata(mem_wdata), .wvalid(mem_wvalid), .wready(mem_wready),
        .bvalid(mem_bvalid), .bready(mem_bready)
    );

endmodule

// File: source/axi_sram.sv
`timescale 1ns/1ps

module axi_sram
    import mem_pkg::*;
#(
    parameter int MEM_WORDS = 256,
    parameter int LATENCY   = 3
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [addr_width-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [data_width-1:0] rdata,
    output logic                  rvalid,
    input  logic                  rready,
    input  logic [addr_width-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [data_width-1:0] wdata,
    input  logic                  wvalid,
    output logic                  wready,
    output logic                  bvalid,
    input  logic                  bready
);

    localparam int idx_width = $clog2(MEM_WORDS);
    localparam int cnt_width = $clog2(LATENCY + 1);

    logic [data_width-1:0] mem [MEM_WORDS];
    sram_state_e           state;
    logic [cnt_width-1:0]  cnt;
    logic                  is_wr;
    logic                  rd_acc;
    logic                  wr_acc;

    // word index, upper address bits ignored
    logic [idx_width-1:0] rd_idx;
    logic [idx_width-1:0] wr_idx;
    assign rd_idx = araddr[idx_width+1:2];
    assign wr_idx = awaddr[idx_width+1:2];

    // reads win a tie; aw and w are only taken together
    assign arready = (state == sram_idle) && arvalid;
    assign awready = (state == sram_idle) && awvalid && wvalid && !arvalid;
    assign wready  = awready;
    assign rd_acc  = arvalid && arready;
    assign wr_acc  = awvalid && awready;

    assign rvalid = (state == sram_resp) && !is_wr;
    assign bvalid = (state == sram_resp) && is_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= sram_idle;
            cnt   <= '0;
            is_wr <= 1'b0;
        end else begin
            case (state)
                sram_idle: begin
                    if (rd_acc || wr_acc) begin
                        is_wr <= wr_acc;
                        if (LATENCY <= 1) begin
                            state <= sram_resp;
                        end else begin
                            state <= sram_wait;
                            cnt   <= cnt_width'(LATENCY - 1);
                        end
                    end
                end
                sram_wait: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == 1) state <= sram_resp;
                end
                sram_resp: begin
                    if ((rvalid && rready) || (bvalid && bready)) begin
                        state <= sram_idle;
                    end
                end
                default: state <= sram_idle;
            endcase
        end
    end

    // array access happens on accept, the response just waits
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            mem[wr_idx] <= wdata;
        end
        if (rd_acc) begin
            rdata <= mem[rd_idx];
        end
    end

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata)
    );

endmodule

// File: source/axi_arbiter.sv
`timescale 1ns/1ps

module axi_arbiter
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // fetch master, read only
    input  logic [addr_width-1:0] ifu_araddr,
    input  logic                  ifu_arvalid,
    output logic                  ifu_arready,
    output logic [data_width-1:0] ifu_rdata,
    output logic                  ifu_rvalid,
    input  logic                  ifu_rready,
    // load/store master
    input  logic [addr_width-1:0] lsu_araddr,
    input  logic                  lsu_arvalid,
    output logic                  lsu_arready,
    output logic [data_width-1:0] lsu_rdata,
    output logic                  lsu_rvalid,
    input  logic                  lsu_rready,
    input  logic [addr_width-1:0] lsu_awaddr,
    input  logic                  lsu_awvalid,
    output logic                  lsu_awready,
    input  logic [data_width-1:0] lsu_wdata,
    input  logic                  lsu_wvalid,
    output logic                  lsu_wready,
    output logic                  lsu_bvalid,
    input  logic                  lsu_bready,
    // shared slave port
    output logic [addr_width-1:0] mem_araddr,
    output logic                  mem_arvalid,
    input  logic                  mem_arready,
    input  logic [data_width-1:0] mem_rdata,
    input  logic                  mem_rvalid,
    output logic                  mem_rready,
    output logic [addr_width-1:0] mem_awaddr,
    output logic                  mem_awvalid,
    input  logic                  mem_awready,
    output logic [data_width-1:0] mem_wdata,
    output logic                  mem_wvalid,
    input  logic                  mem_wready,
    input  logic                  mem_bvalid,
    output logic                  mem_bready
);

    arb_state_e state;
    logic       gnt_ifu;
    logic       gnt_lsu_rd;
    logic       gnt_lsu_wr;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arb_idle;
        end else begin
            case (state)
                arb_idle: begin
                    // lsu traffic goes first
                    if (lsu_arvalid) begin
                        state <= arb_lsu_rd;
                    end else if (lsu_awvalid || lsu_wvalid) begin
                        state <= arb_lsu_wr;
                    end else if (ifu_arvalid) begin
                        state <= arb_ifu_rd;
                    end
                end
                arb_ifu_rd: if (mem_rvalid && ifu_rready) state <= arb_idle;
                arb_lsu_rd: if (mem_rvalid && lsu_rready) state <= arb_idle;
                arb_lsu_wr: if (mem_bvalid && lsu_bready) state <= arb_idle;
                default:    state <= arb_idle;
            endcase
        end
    end

    assign gnt_ifu    = (state == arb_ifu_rd);
    assign gnt_lsu_rd = (state == arb_lsu_rd);
    assign gnt_lsu_wr = (state == arb_lsu_wr);

    // read path, shared by both masters
    assign mem_araddr  = gnt_lsu_rd ? lsu_araddr : ifu_araddr;
    assign mem_arvalid = (gnt_ifu && ifu_arvalid) || (gnt_lsu_rd && lsu_arvalid);
    assign mem_rready  = (gnt_ifu && ifu_rready) || (gnt_lsu_rd && lsu_rready);
    assign ifu_arready = gnt_ifu && mem_arready;
    assign ifu_rvalid  = gnt_ifu && mem_rvalid;
    assign ifu_rdata   = mem_rdata;
    assign lsu_arready = gnt_lsu_rd && mem_arready;
    assign lsu_rvalid  = gnt_lsu_rd && mem_rvalid;
    assign lsu_rdata   = mem_rdata;

    // write path belongs to the lsu alone
    assign mem_awaddr  = lsu_awaddr;
    assign mem_wdata   = lsu_wdata;
    assign mem_awvalid = gnt_lsu_wr && lsu_awvalid;
    assign mem_wvalid  = gnt_lsu_wr && lsu_wvalid;
    assign mem_bready  = gnt_lsu_wr && lsu_bready;
    assign lsu_awready = gnt_lsu_wr && mem_awready;
    assign lsu_wready  = gnt_lsu_wr && mem_wready;
    assign lsu_bvalid  = gnt_lsu_wr && mem_bvalid;

    // a response never outlives its grant, so it cannot reach the next owner
    a_single_owner: assert property (
        @(posedge clk) disable iff (rst)
        state == arb_idle |-> !mem_rvalid && !mem_bvalid
    );

endmodule

// File: source/lsu.sv
`timescale 1ns/1ps

module lsu
    import mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // command port
    input  logic                  lsu_req,
    input  lsu_op_e               lsu_op,
    input  logic [addr_width-1:0] lsu_addr,
    input  logic [data_width-1:0] lsu_wdata,
    output logic                  lsu_busy,
    output logic                  lsu_done,
    output logic [data_width-1:0] lsu_rdata,
    // read channels
    output logic [addr_width-1:0] araddr,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic                  rvalid,
    input  logic [data_width-1:0] rdata,
    output logic                  rready,
    // write channels
    output logic [addr_width-1:0] awaddr,
    output logic                  awvalid,
    input  logic                  awready,
    output logic [data_width-1:0] wdata,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready
);

    logic [addr_width-1:0] addr_q;
    logic                  aw_last;
    logic                  w_last;

    assign araddr = addr_q;
    assign awaddr = addr_q;

    // aw and w may be taken on different edges
    assign aw_last = !awvalid || awready;
    assign w_last  = !wvalid || wready;

    always_ff @(posedge clk) begin
        if (rst) begin
            lsu_busy <= 1'b0;
            lsu_done <= 1'b0;
            arvalid  <= 1'b0;
            rready   <= 1'b0;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            bready   <= 1'b0;
        end else begin
            lsu_done <= 1'b0;
            if (!lsu_busy) begin
                if (lsu_req) begin
                    lsu_busy <= 1'b1;
                    if (lsu_op == op_store) begin
                        awvalid <= 1'b1;
                        wvalid  <= 1'b1;
                    end else begin
                        arvalid <= 1'b1;
                    end
                end
            end else begin
                if (arvalid && arready) begin
                    arvalid <= 1'b0;
                    rready  <= 1'b1;
                end
                if (rvalid && rready) begin
                    rready   <= 1'b0;
                    lsu_done <= 1'b1;
                    lsu_busy <= 1'b0;
                end
                if (awvalid && awready) begin
                    awvalid <= 1'b0;
                end
                if (wvalid && wready) begin
                    wvalid <= 1'b0;
                end
                // both halves of the write gone, wait for b
                if ((awvalid || wvalid) && aw_last && w_last) begin
                    bready <= 1'b1;
                end
                if (bvalid && bready) begin
                    bready   <= 1'b0;
                    lsu_done <= 1'b1;
                    lsu_busy <= 1'b0;
                end
            end
        end
    end

    // command payload, held for the whole transaction
    always_ff @(posedge clk) begin
        if (!lsu_busy && lsu_req) begin
            addr_q <= lsu_addr;
            wdata  <= lsu_wdata;
        end
        if (rvalid && rready) begin
            lsu_rdata <= rdata;
        end
    end

    a_one_direction: assert property (
        @(posedge clk) disable iff (rst)
        !((arvalid || rready) && (awvalid || wvalid || bready))
    );

endmodule

// File: source/ifu.sv
`timescale 1ns/1ps

module ifu
    import mem_pkg::*;
#(
    parameter logic [addr_width-1:0] RESET_PC = 32'h8000_0000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  finish,
    input  logic                  jump_en,
    input  logic [addr_width-1:0] jump_pc,
    output logic [addr_width-1:0] pc,
    output logic [data_width-1:0] inst,
    output logic                  inst_valid,
    output logic                  difftest,
    output logic                  itrace_reg,
    // read address channel
    output logic [addr_width-1:0] araddr,
    output logic                  arvalid,
    input  logic                  arready,
    // read data channel
    input  logic                  rvalid,
    input  logic [data_width-1:0] rdata,
    output logic                  rready
);

    fetch_state_e state;

    // the pc only moves in hold, so it doubles as the read address
    assign araddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= fetch_addr;
            pc         <= RESET_PC;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= 1'b0;
            case (state)
                fetch_addr: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                        state   <= fetch_data;
                    end else begin
                        // first fetch after reset starts here
                        arvalid <= 1'b1;
                    end
                end
                fetch_data: begin
                    if (rvalid && rready) begin
                        rready     <= 1'b0;
                        inst_valid <= 1'b1;
                        state      <= fetch_hold;
                    end
                end
                fetch_hold: begin
                    if (finish) begin
                        pc      <= jump_en ? jump_pc : pc + 32'd4;
                        arvalid <= 1'b1;
                        state   <= fetch_addr;
                    end
                end
                default: state <= fetch_addr;
            endcase
        end
    end

    // instruction word taken on the r handshake
    always_ff @(posedge clk) begin
        if (rvalid && rready) begin
            inst <= rdata;
        end
    end

    // one-cycle strobes following each retire
    always_ff @(posedge clk) begin
        if (rst) begin
            difftest <= 1'b0;
        end else if (finish) begin
            difftest <= 1'b1;
        end else begin
            difftest <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            itrace_reg <= 1'b1;
        end else if (finish) begin
            itrace_reg <= 1'b1;
        end else begin
            itrace_reg <= 1'b0;
        end
    end

    // a stalled address must not change under the arbiter
    a_araddr_stable: assert property (
        @(posedge clk) disable iff (rst)
        arvalid && !arready |=> $stable(araddr)
    );

endmodule

// File: source/mem_pkg.sv
package mem_pkg;

    // bus widths shared by every block
    localparam int addr_width = 32;
    localparam int data_width = 32;

    // command opcode on the lsu port
    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } lsu_op_e;

    // owner of the shared slave port
    typedef enum logic [1:0] {
        arb_idle   = 2'd0,
        arb_ifu_rd = 2'd1,
        arb_lsu_rd = 2'd2,
        arb_lsu_wr = 2'd3
    } arb_state_e;

    typedef enum logic [1:0] {
        sram_idle = 2'd0,
        sram_wait = 2'd1,
        sram_resp = 2'd2
    } sram_state_e;

    // fetch sequence: address phase, data phase, wait for retire
    typedef enum logic [1:0] {
        fetch_addr = 2'd0,
        fetch_data = 2'd1,
        fetch_hold = 2'd2
    } fetch_state_e;

endpackage
